// ==== source/rvPkg.sv ====
package rvPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // major opcodes of the supported subset, anything else is a no-op
    typedef enum logic [6:0] {
        opcReg    = 7'b0110011,
        opcImm    = 7'b0010011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcBranch = 7'b1100011,
        opcJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // execute operand source
    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,
        fwdWb
    } fwdSelT;

endpackage

// ==== source/fetchUnit.sv ====
module fetchUnit import rvPkg::*; #(
    parameter int imemWords = 256
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,
    input  logic            redirect,
    input  logic [xlen-1:0] redirectPc,
    input  logic            imemWe,
    input  logic [xlen-1:0] imemAddr,
    input  logic [31:0]     imemData,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] ifInstr,
    output logic [xlen-1:0] ifPc
);
    localparam int idxW = $clog2(imemWords);
    // addi x0, x0, 0
    localparam logic [31:0] nopInstr = 32'h0000_0013;

    logic [31:0] imem [imemWords];
    logic [31:0] fetched;

    // load port takes a byte address, low two bits dropped
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr[idxW+1:2]] <= imemData;
        end
    end

    assign fetched = imem[pc[idxW+1:2]];

    // redirect wins over a load-use hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ifInstr <= nopInstr;
        end else if (!stall) begin
            ifInstr <= fetched;
            ifPc    <= pc;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !flush |-> !(redirect && stall))
        else $error("redirect and stall together without flush");

endmodule

// ==== source/regFile.sv ====
module regFile import rvPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    input  logic [regAddrW-1:0] wbRd,
    input  logic                wbRegWrite,
    input  logic [xlen-1:0]     wbData,
    output logic [xlen-1:0]     rdata1,
    output logic [xlen-1:0]     rdata2
);
    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRegWrite && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    // same-cycle write shows up on the read side
    function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wbRegWrite && wbRd == addr) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = readPort(rs1);
        rdata2 = readPort(rs2);
    end

endmodule

// ==== source/decodeUnit.sv ====
module decodeUnit import rvPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    input  logic [xlen-1:0]     ifInstr,
    input  logic [xlen-1:0]     ifPc,
    input  logic [xlen-1:0]     rdata1,
    input  logic [xlen-1:0]     rdata2,
    output logic [regAddrW-1:0] rs1,
    output logic [regAddrW-1:0] rs2,
    output logic [regAddrW-1:0] idExRs1,
    output logic [regAddrW-1:0] idExRs2,
    output logic [regAddrW-1:0] idExRd,
    output logic [xlen-1:0]     idExRdata1,
    output logic [xlen-1:0]     idExRdata2,
    output logic [xlen-1:0]     idExImm,
    output logic [xlen-1:0]     idExPc,
    output aluOpT               idExAluOp,
    output logic                idExUseImm,
    output logic                idExRegWrite,
    output logic                idExMemRead,
    output logic                idExMemWrite,
    output logic                idExBranch,
    output logic                idExBranchNe,
    output logic                idExJal
);
    opcodeT          opc;
    logic [2:0]      funct3;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immJ;
    logic [xlen-1:0] imm;
    aluOpT           aluOp;
    logic            useImm;
    logic            regWrite;
    logic            memRead;
    logic            memWrite;
    logic            branch;
    logic            branchNe;
    logic            jal;

    assign opc    = opcodeT'(ifInstr[6:0]);
    assign funct3 = ifInstr[14:12];
    assign rs1    = ifInstr[19:15];
    assign rs2    = ifInstr[24:20];

    assign immI = {{20{ifInstr[31]}}, ifInstr[31:20]};
    assign immS = {{20{ifInstr[31]}}, ifInstr[31:25], ifInstr[11:7]};
    assign immB = {{19{ifInstr[31]}}, ifInstr[31], ifInstr[7], ifInstr[30:25],
                   ifInstr[11:8], 1'b0};
    assign immJ = {{11{ifInstr[31]}}, ifInstr[31], ifInstr[19:12], ifInstr[20],
                   ifInstr[30:21], 1'b0};

    always_comb begin
        imm      = immI;
        aluOp    = aluAdd;
        useImm   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        jal      = 1'b0;
        case (opc)
            opcReg: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOp = ifInstr[30] ? aluSub : aluAdd;
                    3'b010:  aluOp = aluSlt;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    default: regWrite = 1'b0;
                endcase
            end
            // only addi among the immediate ops
            opcImm: begin
                useImm   = 1'b1;
                regWrite = (funct3 == 3'b000);
            end
            // word access only
            opcLoad: begin
                useImm   = 1'b1;
                regWrite = (funct3 == 3'b010);
                memRead  = (funct3 == 3'b010);
            end
            opcStore: begin
                imm      = immS;
                useImm   = 1'b1;
                memWrite = (funct3 == 3'b010);
            end
            opcBranch: begin
                imm      = immB;
                branch   = (funct3 == 3'b000 || funct3 == 3'b001);
                branchNe = funct3[0];
            end
            opcJal: begin
                imm      = immJ;
                regWrite = 1'b1;
                jal      = 1'b1;
            end
            default: begin
                imm = immI;
            end
        endcase
    end

    // ID/EX, bubble on stall or flush
    always_ff @(posedge clk) begin
        if (rst || stall || flush) begin
            idExRegWrite <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExBranch   <= 1'b0;
            idExJal      <= 1'b0;
        end else begin
            idExRegWrite <= regWrite;
            idExMemRead  <= memRead;
            idExMemWrite <= memWrite;
            idExBranch   <= branch;
            idExJal      <= jal;
        end
        idExRs1      <= rs1;
        idExRs2      <= rs2;
        idExRd       <= ifInstr[11:7];
        idExRdata1   <= rdata1;
        idExRdata2   <= rdata2;
        idExImm      <= imm;
        idExPc       <= ifPc;
        idExAluOp    <= aluOp;
        idExUseImm   <= useImm;
        idExBranchNe <= branchNe;
    end

endmodule

// ==== source/hazardUnit.sv ====
module hazardUnit import rvPkg::*; (
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    input  logic [regAddrW-1:0] idExRs1,
    input  logic [regAddrW-1:0] idExRs2,
    input  logic [regAddrW-1:0] idExRd,
    input  logic [regAddrW-1:0] exMemRd,
    input  logic [regAddrW-1:0] wbRd,
    input  logic                idExMemRead,
    input  logic                exMemRegWrite,
    input  logic                wbRegWrite,
    output logic                stall,
    output fwdSelT              fwdA,
    output fwdSelT              fwdB
);
    // nearest producer first
    function automatic fwdSelT pick(input logic [regAddrW-1:0] src);
        if (exMemRegWrite && exMemRd != '0 && exMemRd == src) begin
            return fwdMem;
        end
        if (wbRegWrite && wbRd != '0 && wbRd == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    always_comb begin
        // load result not ready until after MEM
        stall = idExMemRead && idExRd != '0 && (idExRd == rs1 || idExRd == rs2);
        fwdA  = pick(idExRs1);
        fwdB  = pick(idExRs2);
    end

endmodule

// ==== source/aluUnit.sv ====
module aluUnit import rvPkg::*; (
    input  fwdSelT          fwdA,
    input  fwdSelT          fwdB,
    input  logic [xlen-1:0] idExRdata1,
    input  logic [xlen-1:0] idExRdata2,
    input  logic [xlen-1:0] idExImm,
    input  logic [xlen-1:0] exMemResult,
    input  logic [xlen-1:0] wbData,
    input  logic            idExUseImm,
    input  aluOpT           idExAluOp,
    output logic [xlen-1:0] opA,
    output logic [xlen-1:0] opB,
    output logic [xlen-1:0] aluResult,
    output logic [xlen-1:0] storeData
);
    logic [xlen-1:0] srcB;

    function automatic logic [xlen-1:0] fwdMux(input fwdSelT sel,
                                               input logic [xlen-1:0] regVal);
        case (sel)
            fwdMem:  return exMemResult;
            fwdWb:   return wbData;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        opA  = fwdMux(fwdA, idExRdata1);
        opB  = fwdMux(fwdB, idExRdata2);
        srcB = idExUseImm ? idExImm : opB;
        case (idExAluOp)
            aluAdd:  aluResult = opA + srcB;
            aluSub:  aluResult = opA - srcB;
            aluAnd:  aluResult = opA & srcB;
            aluOr:   aluResult = opA | srcB;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, $signed(opA) < $signed(srcB)};
            default: aluResult = '0;
        endcase
    end

    // rs2 after forwarding, before the immediate mux
    assign storeData = opB;

endmodule

// ==== source/branchUnit.sv ====
module branchUnit import rvPkg::*; (
    input  logic [xlen-1:0] opA,
    input  logic [xlen-1:0] opB,
    input  logic [xlen-1:0] idExPc,
    input  logic [xlen-1:0] idExImm,
    input  logic            idExBranch,
    input  logic            idExBranchNe,
    input  logic            idExJal,
    output logic            redirect,
    output logic            flush,
    output logic [xlen-1:0] redirectPc,
    output logic [xlen-1:0] linkValue
);
    logic taken;

    always_comb begin
        taken      = idExBranch && (idExBranchNe ? (opA != opB) : (opA == opB));
        redirect   = taken || idExJal;
        // predicted not taken, so both younger slots are wrong
        flush      = redirect;
        redirectPc = idExPc + idExImm;
        linkValue  = idExPc + 32'd4;
        if (redirect) begin
            assert (redirectPc[1:0] == 2'b00)
                else $error("misaligned redirect target %h", redirectPc);
        end
    end

endmodule

// ==== source/memStage.sv ====
module memStage import rvPkg::*; #(
    parameter int dmemWords = 256
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [xlen-1:0]     aluResult,
    input  logic [xlen-1:0]     linkValue,
    input  logic [xlen-1:0]     storeData,
    input  logic [regAddrW-1:0] idExRd,
    input  logic                idExRegWrite,
    input  logic                idExMemRead,
    input  logic                idExMemWrite,
    input  logic                idExJal,
    output logic [xlen-1:0]     exMemResult,
    output logic [regAddrW-1:0] exMemRd,
    output logic                exMemRegWrite,
    output logic                wbRegWrite,
    output logic [regAddrW-1:0] wbRd,
    output logic [xlen-1:0]     wbData,
    output logic                retireValid
);
    localparam int idxW = $clog2(dmemWords);

    logic [xlen-1:0] dmem [dmemWords];
    logic            exMemMemRead;
    logic            exMemMemWrite;
    logic [xlen-1:0] exMemStore;
    logic [xlen-1:0] loadData;

    // EX/MEM, JAL writes its link address instead of the ALU result
    always_ff @(posedge clk) begin
        if (rst) begin
            exMemRegWrite <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
        end else begin
            exMemRegWrite <= idExRegWrite;
            exMemMemRead  <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
        end
        exMemResult <= idExJal ? linkValue : aluResult;
        exMemRd     <= idExRd;
        exMemStore  <= storeData;
    end

    assign loadData = dmem[exMemResult[idxW+1:2]];

    always_ff @(posedge clk) begin
        if (exMemMemWrite) begin
            dmem[exMemResult[idxW+1:2]] <= exMemStore;
        end
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite  <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            wbRegWrite  <= exMemRegWrite;
            retireValid <= exMemRegWrite && exMemRd != '0;
        end
        wbRd   <= exMemRd;
        wbData <= exMemMemRead ? loadData : exMemResult;
    end

endmodule

// ==== source/cpuTop.sv ====
module cpuTop import rvPkg::*; #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                imemWe,
    input  logic [xlen-1:0]     imemAddr,
    input  logic [31:0]         imemData,
    output logic [7:0]          debugPc,
    output logic                retireValid,
    output logic [regAddrW-1:0] retireRd,
    output logic [xlen-1:0]     retireData
);
    // fetch
    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     ifInstr;
    logic [xlen-1:0]     ifPc;

    // decode and ID/EX
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [xlen-1:0]     rdata1;
    logic [xlen-1:0]     rdata2;
    logic [regAddrW-1:0] idExRs1;
    logic [regAddrW-1:0] idExRs2;
    logic [regAddrW-1:0] idExRd;
    logic [xlen-1:0]     idExRdata1;
    logic [xlen-1:0]     idExRdata2;
    logic [xlen-1:0]     idExImm;
    logic [xlen-1:0]     idExPc;
    aluOpT               idExAluOp;
    logic                idExUseImm;
    logic                idExRegWrite;
    logic                idExMemRead;
    logic                idExMemWrite;
    logic                idExBranch;
    logic                idExBranchNe;
    logic                idExJal;

    // hazards and execute
    logic                stall;
    fwdSelT              fwdA;
    fwdSelT              fwdB;
    logic [xlen-1:0]     opA;
    logic [xlen-1:0]     opB;
    logic [xlen-1:0]     aluResult;
    logic [xlen-1:0]     storeData;
    logic                redirect;
    logic                flush;
    logic [xlen-1:0]     redirectPc;
    logic [xlen-1:0]     linkValue;

    // memory and writeback
    logic [xlen-1:0]     exMemResult;
    logic [regAddrW-1:0] exMemRd;
    logic                exMemRegWrite;
    logic                wbRegWrite;
    logic [regAddrW-1:0] wbRd;
    logic [xlen-1:0]     wbData;

    fetchUnit #(.imemWords(imemWords)) uFetch (.*);
    regFile uRegs (.*);
    decodeUnit uDecode (.*);
    hazardUnit uHazard (.*);
    aluUnit uAlu (.*);
    branchUnit uBranch (.*);
    memStage #(.dmemWords(dmemWords)) uMem (.*);

    assign debugPc    = pc[7:0];
    assign retireRd   = wbRd;
    assign retireData = wbData;

endmodule

// ==== verification/cpuTb.sv ====
module cpuTb import rvPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int numTests      = 6;
    localparam int timeoutCycles = 400 * numTests;
    // long enough for a wrongly fetched instruction to reach writeback
    localparam int drainCycles   = 12;
    localparam logic [31:0] lcgSeed = 32'h2c2bae36;

    // {funct7, funct3} of the register ops
    localparam logic [9:0] fnAdd = 10'b0000000_000;
    localparam logic [9:0] fnSub = 10'b0100000_000;
    localparam logic [9:0] fnAnd = 10'b0000000_111;
    localparam logic [9:0] fnOr  = 10'b0000000_110;
    localparam logic [9:0] fnSlt = 10'b0000000_010;
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    logic                clk;
    logic                rst;
    logic                imemWe;
    logic [xlen-1:0]     imemAddr;
    logic [31:0]         imemData;
    logic [7:0]          debugPc;
    logic                retireValid;
    logic [regAddrW-1:0] retireRd;
    logic [xlen-1:0]     retireData;

    logic [31:0]         lcgState;
    int                  cycleCount;
    logic [31:0]         progQ [$];
    logic [regAddrW-1:0] expRdQ [$];
    logic [xlen-1:0]     expDataQ [$];
    logic [regAddrW-1:0] gotRdQ [$];
    logic [xlen-1:0]     gotDataQ [$];

    cpuTop dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("timeout after %0d cycles, the DUT stopped retiring", timeoutCycles);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // upper bits of the LCG are the better ones
    function automatic logic [11:0] randImm();
        logic [31:0] r;
        r = nextRandom();
        return r[27:16];
    endfunction

    function automatic logic [xlen-1:0] sext12(input logic [11:0] v);
        return {{(xlen-12){v[11]}}, v};
    endfunction

    function automatic logic [31:0] regOp(input logic [9:0] fn, input int rd, rs1, rs2);
        return {fn[9:3], rs2[4:0], rs1[4:0], fn[2:0], rd[4:0], opcReg};
    endfunction

    function automatic logic [31:0] addi(input int rd, rs1, input logic [11:0] imm);
        return {imm, rs1[4:0], 3'b000, rd[4:0], opcImm};
    endfunction

    function automatic logic [31:0] lw(input int rd, rs1, input logic [11:0] imm);
        return {imm, rs1[4:0], 3'b010, rd[4:0], opcLoad};
    endfunction

    function automatic logic [31:0] sw(input int rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opcStore};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opcBranch};
    endfunction

    function automatic logic [31:0] jal(input int rd, off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opcJal};
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkReg(input string name, input logic [regAddrW-1:0] got, exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic checkWord(input string name, input logic [xlen-1:0] got, exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0d ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0d ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0d ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic expectRetire(input int rd, input logic [xlen-1:0] data);
        expRdQ.push_back(rd[regAddrW-1:0]);
        expDataQ.push_back(data);
    endtask

    // 16 reset cycles, one program word written per cycle
    task automatic resetAndLoad();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (i > 0) begin
                checkBit("retireValid", retireValid, 1'b0);
                checkByte("debugPc", debugPc, 8'h00);
            end
            rst    = 1'b1;
            imemWe = 1'b0;
            if (i < progQ.size()) begin
                imemWe   = 1'b1;
                imemAddr = i * 4;
                imemData = progQ[i];
            end
        end
        @(negedge clk);
        rst    = 1'b0;
        imemWe = 1'b0;
    endtask

    task automatic sampleRetire();
        @(negedge clk);
        if (retireValid) begin
            gotRdQ.push_back(retireRd);
            gotDataQ.push_back(retireData);
        end
    endtask

    task automatic runProgram();
        resetAndLoad();
        gotRdQ.delete();
        gotDataQ.delete();
        while (gotRdQ.size() < expRdQ.size()) begin
            sampleRetire();
        end
        // anything retiring now came from a skipped slot
        repeat (drainCycles) sampleRetire();
        foreach (expRdQ[i]) begin
            checkReg("retireRd", gotRdQ[i], expRdQ[i]);
            checkWord("retireData", gotDataQ[i], expDataQ[i]);
        end
        if (gotRdQ.size() != expRdQ.size()) begin
            abortRun($sformatf("%0d instructions retired where %0d were expected",
                               gotRdQ.size(), expRdQ.size()));
        end
        progQ.delete();
        expRdQ.delete();
        expDataQ.delete();
    endtask

    task automatic aluTest();
        logic [11:0]     a;
        logic [11:0]     b;
        logic [xlen-1:0] va;
        logic [xlen-1:0] vb;
        a  = randImm();
        b  = randImm();
        va = sext12(a);
        vb = sext12(b);
        progQ = '{addi(1, 0, a), addi(2, 0, b), regOp(fnAdd, 3, 1, 2), regOp(fnSub, 4, 1, 2),
                  regOp(fnAnd, 5, 1, 2), regOp(fnOr, 6, 1, 2), regOp(fnSlt, 7, 1, 2),
                  regOp(fnSlt, 8, 2, 1), jal(0, 0)};
        expectRetire(1, va);
        expectRetire(2, vb);
        expectRetire(3, va + vb);
        expectRetire(4, va - vb);
        expectRetire(5, va & vb);
        expectRetire(6, va | vb);
        expectRetire(7, ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0);
        expectRetire(8, ($signed(vb) < $signed(va)) ? 32'd1 : 32'd0);
        runProgram();
    endtask

    // consumers one, two and three slots behind their producers
    task automatic forwardTest();
        logic [xlen-1:0] va;
        logic [xlen-1:0] vc;
        logic [11:0]     a;
        logic [11:0]     c;
        a  = randImm();
        c  = randImm();
        va = sext12(a);
        vc = sext12(c);
        progQ = '{addi(1, 0, a), regOp(fnAdd, 2, 1, 1), regOp(fnAdd, 3, 2, 1), addi(4, 0, c),
                  regOp(fnAdd, 5, 2, 4), regOp(fnSub, 6, 3, 5), jal(0, 0)};
        expectRetire(1, va);
        expectRetire(2, va + va);
        expectRetire(3, va + va + va);
        expectRetire(4, vc);
        expectRetire(5, va + va + vc);
        expectRetire(6, (va + va + va) - (va + va + vc));
        runProgram();
    endtask

    task automatic loadUseTest();
        logic [11:0]     a;
        logic [11:0]     b;
        logic [11:0]     t;
        logic [11:0]     addr;
        logic [xlen-1:0] va;
        logic [xlen-1:0] vb;
        a    = randImm();
        b    = randImm();
        t    = randImm();
        addr = {2'b00, t[7:0], 2'b00};
        va   = sext12(a);
        vb   = sext12(b);
        progQ = '{addi(1, 0, a), addi(2, 0, addr), addi(5, 0, b), sw(1, 2, 12'd0),
                  lw(3, 2, 12'd0), regOp(fnAdd, 4, 3, 5), regOp(fnAdd, 6, 4, 3), jal(0, 0)};
        expectRetire(1, va);
        expectRetire(2, {20'd0, addr});
        expectRetire(5, vb);
        expectRetire(3, va);
        expectRetire(4, va + vb);
        expectRetire(6, va + vb + va);
        runProgram();
    endtask

    task automatic branchTest();
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        a = randImm();
        b = a ^ 12'h001;
        c = randImm();
        progQ = '{addi(1, 0, a), addi(2, 0, a),
                  branch(f3Beq, 1, 2, 12), addi(3, 0, 12'd1), addi(4, 0, 12'd2),
                  branch(f3Bne, 1, 2, 8), addi(5, 0, b),
                  branch(f3Bne, 1, 5, 8), addi(6, 0, 12'd3),
                  branch(f3Beq, 1, 5, 8), addi(7, 0, c), jal(0, 0)};
        expectRetire(1, sext12(a));
        expectRetire(2, sext12(a));
        expectRetire(5, sext12(b));
        expectRetire(7, sext12(c));
        runProgram();
    endtask

    task automatic jalTest();
        logic [11:0]     a;
        logic [xlen-1:0] va;
        a  = randImm();
        va = sext12(a);
        // jump at address 4 lands on address 16
        progQ = '{addi(1, 0, a), jal(5, 12), addi(2, 0, 12'd1), addi(3, 0, 12'd2),
                  regOp(fnAdd, 4, 5, 1), jal(0, 0)};
        expectRetire(1, va);
        expectRetire(5, 32'd8);
        expectRetire(4, 32'd8 + va);
        runProgram();
    endtask

    task automatic resetStateTest();
        logic [11:0] a;
        logic [11:0] b;
        a = randImm();
        b = randImm();
        progQ = '{addi(0, 0, a), addi(1, 0, b), regOp(fnAdd, 0, 1, 1),
                  regOp(fnAdd, 2, 0, 1), jal(0, 0)};
        expectRetire(1, sext12(b));
        expectRetire(2, sext12(b));
        runProgram();
    endtask

    initial begin
        rst      = 1'b1;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        lcgState = lcgSeed;
        aluTest();
        forwardTest();
        loadUseTest();
        branchTest();
        jalTest();
        resetStateTest();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
source/rvPkg.sv
source/fetchUnit.sv
source/regFile.sv
source/decodeUnit.sv
source/hazardUnit.sv
source/aluUnit.sv
source/branchUnit.sv
source/memStage.sv
source/cpuTop.sv
verification/cpuTb.sv

// ==== Makefile ====
TB = cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module cpuTop

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TB) -o $(TB)Sim
	out=$$(./obj_dir/$(TB)Sim); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
